/* files.f */
design/soc_pkg.sv
design/bus_decoder.sv
design/data_ram.sv
design/rst_ctrl.sv
design/mtimer.sv
design/gpio_csr.sv
design/soc_top.sv
dv/soc_tb.sv

/* dv/soc_tb.sv */
// peripheral fabric testbench
module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RAM_BURST    = 32;
  localparam int TMR_GAP      = 10;
  localparam int IRQ_WAIT_MAX = 100;
  localparam int N_TBL        = 13;
  // several cycles per table entry, burst beat and timer step
  localparam int WATCHDOG_CYCLES = 4 * (N_TBL + RAM_BURST + IRQ_WAIT_MAX + 20);

  // side output checked after a table entry
  typedef enum logic [2:0] {SIDE_NONE, SIDE_BOOT, SIDE_FETCH, SIDE_CSR, SIDE_IRQ} side_e;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    side_e       side;
    logic [31:0] side_val;
  } tbl_entry_t;

  // reset controller, gpio, unknown offsets and unmapped accesses
  localparam tbl_entry_t TABLE [N_TBL] = '{
    '{1'b1, RST_BASE + RST_ADDR_OFS, 32'h2000_0103, 32'h0, 1'b0, SIDE_BOOT, 32'h2000_0100},
    '{1'b0, RST_BASE + RST_ADDR_OFS, 32'h0, 32'h2000_0100, 1'b0, SIDE_BOOT, 32'h2000_0100},
    '{1'b1, RST_BASE + RST_CTRL_OFS, 32'h1, 32'h0, 1'b0, SIDE_FETCH, 32'h1},
    '{1'b0, RST_BASE + RST_CTRL_OFS, 32'h0, 32'h1, 1'b0, SIDE_FETCH, 32'h1},
    '{1'b1, GPIO_BASE + GPIO_OUT_OFS, 32'hABCD_125A, 32'h0, 1'b0, SIDE_CSR, 32'h5A},
    '{1'b0, GPIO_BASE + GPIO_OUT_OFS, 32'h0, 32'h5A, 1'b0, SIDE_CSR, 32'h5A},
    '{1'b0, GPIO_BASE + 32'h10, 32'h0, 32'h0, 1'b0, SIDE_NONE, 32'h0},
    '{1'b1, GPIO_BASE + 32'h10, 32'h33, 32'h0, 1'b0, SIDE_CSR, 32'h5A},
    '{1'b1, 32'h5000_0000, 32'hFFFF_FFFF, 32'h0, 1'b1, SIDE_CSR, 32'h5A},
    '{1'b0, 32'h5000_0000, 32'h0, 32'h0, 1'b1, SIDE_BOOT, 32'h2000_0100},
    '{1'b0, GPIO_BASE + GPIO_OUT_OFS, 32'h0, 32'h5A, 1'b0, SIDE_CSR, 32'h5A},
    '{1'b0, RST_BASE + RST_ADDR_OFS, 32'h0, 32'h2000_0100, 1'b0, SIDE_FETCH, 32'h1},
    '{1'b0, TIMER_BASE + CMP_HI_OFS, 32'h0, 32'hFFFF_FFFF, 1'b0, SIDE_IRQ, 32'h0}
  };

  logic        clk = 1'b0;
  logic        arst_n_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic        rsp_o;
  logic        err_o;
  logic [31:0] rdata_o;
  logic [31:0] boot_addr_o;
  logic        fetch_en_o;
  logic        mtimer_irq_o;
  logic [7:0]  csr_o;

  // ram model of addresses and stored words
  logic [31:0] ram_addr [RAM_BURST];
  logic [31:0] ram_data [RAM_BURST];

  soc_top #(
    .RAM_WORDS (2048)
  ) i_dut (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rsp_o        (rsp_o),
    .err_o        (err_o),
    .rdata_o      (rdata_o),
    .boot_addr_o  (boot_addr_o),
    .fetch_en_o   (fetch_en_o),
    .mtimer_irq_o (mtimer_irq_o),
    .csr_o        (csr_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        stop_on_error();
      end
  endtask

  // response strobe and error flag sampled mid-cycle
  task automatic check_rsp(input logic exp_err);
    assert (rsp_o === 1'b1)
      else begin
        $display("Error at %0t ns: no response one cycle after the request", $time);
        stop_on_error();
      end
    check_value("err_o", {31'b0, err_o}, {31'b0, exp_err});
  endtask

  task automatic check_side(input side_e side, input logic [31:0] val);
    case (side)
      SIDE_BOOT:  check_value("boot_addr_o", boot_addr_o, val);
      SIDE_FETCH: check_value("fetch_en_o", {31'b0, fetch_en_o}, val);
      SIDE_CSR:   check_value("csr_o", {24'b0, csr_o}, val);
      SIDE_IRQ:   check_value("mtimer_irq_o", {31'b0, mtimer_irq_o}, val);
      default: ;
    endcase
  endtask

  // one request that returns at the negedge of the response cycle
  task automatic single_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic exp_err,
                               output logic [31:0] rdata);
    @(posedge clk);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(posedge clk);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk);
    check_rsp(exp_err);
    if (we) begin
      check_value("write response data", rdata_o, 32'h0);
    end
    rdata = rdata_o;
  endtask

  // back-to-back ram accesses with reads in reverse order
  task automatic ram_burst(input logic we);
    int idx;
    int prev;
    prev = 0;
    for (int i = 0; i <= RAM_BURST; i++) begin
      idx = we ? i : RAM_BURST - 1 - i;
      @(posedge clk);
      req_i   <= (i < RAM_BURST);
      we_i    <= we;
      addr_i  <= (i < RAM_BURST) ? ram_addr[idx] : 32'h0;
      wdata_i <= (i < RAM_BURST) ? ram_data[idx] : 32'h0;
      @(negedge clk);
      if (i > 0) begin
        check_rsp(1'b0);
        check_value(we ? "ram write response" : "ram read data", rdata_o,
                    we ? 32'h0 : ram_data[prev]);
      end
      prev = idx;
    end
  endtask

  // hang guard
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the simulation hung");
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] seed;
    int          k;
    arst_n_i = 1'b0;
    req_i    = 1'b0;
    we_i     = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    seed     = 32'h8142;
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;

    // reset values with the bus idle
    @(negedge clk);
    check_value("rsp_o after reset", {31'b0, rsp_o}, 32'h0);
    check_value("err_o after reset", {31'b0, err_o}, 32'h0);
    check_value("fetch_en_o after reset", {31'b0, fetch_en_o}, 32'h0);
    check_value("csr_o after reset", {24'b0, csr_o}, 32'h0);
    check_value("boot_addr_o after reset", boot_addr_o, DEFAULT_BOOT_ADDR);
    check_value("mtimer_irq_o after reset", {31'b0, mtimer_irq_o}, 32'h0);

    for (int i = 0; i < N_TBL; i++) begin
      single_access(TABLE[i].we, TABLE[i].addr, TABLE[i].wdata, TABLE[i].exp_err, rd);
      check_value("read data", rd, TABLE[i].exp_rdata);
      check_side(TABLE[i].side, TABLE[i].side_val);
    end

    // distinct word offsets with lcg data
    for (int i = 0; i < RAM_BURST; i++) begin
      seed        = lcg_next(seed);
      ram_data[i] = seed;
      ram_addr[i] = RAM_BASE + ((i * 37 + 5) % 2048) * 4;
    end
    ram_burst(1'b1);
    ram_burst(1'b0);

    // mtime advances at least one per cycle
    single_access(1'b0, TIMER_BASE + TMR_LO_OFS, 32'h0, 1'b0, t0);
    repeat (TMR_GAP) @(posedge clk);
    single_access(1'b0, TIMER_BASE + TMR_LO_OFS, 32'h0, 1'b0, t1);
    assert ((t1 - t0) >= TMR_GAP)
      else begin
        $display("Error at %0t ns: mtime went from %h to %h in %0d cycles", $time, t0,
                 t1, TMR_GAP);
        stop_on_error();
      end

    // low half first so the compare never passes early
    single_access(1'b1, TIMER_BASE + CMP_LO_OFS, t1 + 32'd50, 1'b0, rd);
    single_access(1'b1, TIMER_BASE + CMP_HI_OFS, 32'h0, 1'b0, rd);
    check_value("mtimer_irq_o before compare", {31'b0, mtimer_irq_o}, 32'h0);
    for (k = 0; k < IRQ_WAIT_MAX && !mtimer_irq_o; k++) begin
      @(negedge clk);
    end
    assert (mtimer_irq_o === 1'b1)
      else begin
        $display("Timer interrupt did not rise within %0d cycles", IRQ_WAIT_MAX);
        stop_on_error();
      end

    // park the compare again
    single_access(1'b1, TIMER_BASE + CMP_HI_OFS, 32'hFFFF_FFFF, 1'b0, rd);
    @(posedge clk);
    @(negedge clk);
    check_value("mtimer_irq_o after parking", {31'b0, mtimer_irq_o}, 32'h0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* design/soc_top.sv */
// peripheral fabric top level
module soc_top #(
  parameter int RAM_WORDS = 2048
) (
  input  logic                       clk,
  input  logic                       arst_n_i,
  // master bus
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  output logic                       rsp_o,
  output logic                       err_o,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  // core start controls
  output logic [soc_pkg::ADDR_W-1:0] boot_addr_o,
  output logic                       fetch_en_o,
  // timer interrupt
  output logic                       mtimer_irq_o,
  // gpio pins
  output logic [7:0]                 csr_o
);
  import soc_pkg::*;

  // per-slave selects and read data
  logic [N_SLAVES-1:0]             slv_sel;
  logic [N_SLAVES-1:0][DATA_W-1:0] slv_rdata;
  // broadcast request lines
  logic                            slv_we;
  logic [WIN_BITS-1:0]             slv_offset;
  logic [DATA_W-1:0]               slv_wdata;

  bus_decoder u_bus_decoder (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .rsp_o    (rsp_o),
    .err_o    (err_o),
    .rdata_o  (rdata_o),
    .sel_o    (slv_sel),
    .we_o     (slv_we),
    .offset_o (slv_offset),
    .wdata_o  (slv_wdata),
    .rdata_i  (slv_rdata)
  );

  // data ram at 0x1000_0000
  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .sel_i    (slv_sel[SLV_RAM]),
    .we_i     (slv_we),
    .offset_i (slv_offset),
    .wdata_i  (slv_wdata),
    .rdata_o  (slv_rdata[SLV_RAM])
  );

  // boot controls at 0xC000_0000
  rst_ctrl u_rst_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .sel_i       (slv_sel[SLV_RST]),
    .we_i        (slv_we),
    .offset_i    (slv_offset),
    .wdata_i     (slv_wdata),
    .rdata_o     (slv_rdata[SLV_RST]),
    .boot_addr_o (boot_addr_o),
    .fetch_en_o  (fetch_en_o)
  );

  // gpio at 0xD000_0000
  gpio_csr u_gpio_csr (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .sel_i    (slv_sel[SLV_GPIO]),
    .we_i     (slv_we),
    .offset_i (slv_offset),
    .wdata_i  (slv_wdata),
    .rdata_o  (slv_rdata[SLV_GPIO]),
    .csr_o    (csr_o)
  );

  // timer at 0xF000_0000
  mtimer u_mtimer (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .sel_i        (slv_sel[SLV_TIMER]),
    .we_i         (slv_we),
    .offset_i     (slv_offset),
    .wdata_i      (slv_wdata),
    .rdata_o      (slv_rdata[SLV_TIMER]),
    .mtimer_irq_o (mtimer_irq_o)
  );

endmodule

/* design/gpio_csr.sv */
// gpio output control register
module gpio_csr (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [soc_pkg::WIN_BITS-1:0] offset_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic [7:0]                   csr_o
);
  import soc_pkg::*;

  logic out_hit;

  // only one register lives in this window
  assign out_hit = (offset_i == GPIO_OUT_OFS);

  // low byte of the write lands on the pins
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      csr_o <= '0;
    end else if (sel_i && we_i && out_hit) begin
      csr_o <= wdata_i[7:0];
    end
  end

  // zero-extended readback
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (sel_i && !we_i && out_hit) begin
      rdata_o <= {{(DATA_W-8){1'b0}}, csr_o};
    end else begin
      rdata_o <= '0;
    end
  end

endmodule

/* design/mtimer.sv */
// machine timer with compare interrupt
module mtimer (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [soc_pkg::WIN_BITS-1:0] offset_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic                         mtimer_irq_o
);
  import soc_pkg::*;

  // timer spans two bus words
  localparam int MT_W = 2 * DATA_W;

  logic [MT_W-1:0] mtime_q;
  logic [MT_W-1:0] mtimecmp_q;
  logic            wr_en;
  logic            rd_en;
  logic            cmp_hit;

  assign wr_en = sel_i & we_i;
  assign rd_en = sel_i & ~we_i;

  // free-running counter
  // a bus write wins over the increment for that cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q <= '0;
    end else if (wr_en && (offset_i == TMR_LO_OFS)) begin
      mtime_q <= {mtime_q[MT_W-1:DATA_W], wdata_i};
    end else if (wr_en && (offset_i == TMR_HI_OFS)) begin
      mtime_q <= {wdata_i, mtime_q[DATA_W-1:0]};
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // compare value, all ones keeps the interrupt quiet
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtimecmp_q <= '1;
    end else if (wr_en && (offset_i == CMP_LO_OFS)) begin
      mtimecmp_q <= {mtimecmp_q[MT_W-1:DATA_W], wdata_i};
    end else if (wr_en && (offset_i == CMP_HI_OFS)) begin
      mtimecmp_q <= {wdata_i, mtimecmp_q[DATA_W-1:0]};
    end
  end

  assign cmp_hit = (mtime_q >= mtimecmp_q);

  // level interrupt, one cycle behind the compare
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtimer_irq_o <= 1'b0;
    end else begin
      mtimer_irq_o <= cmp_hit;
    end
  end

  // readback of both halves of both registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      case (offset_i)
        TMR_LO_OFS: rdata_o <= mtime_q[DATA_W-1:0];
        TMR_HI_OFS: rdata_o <= mtime_q[MT_W-1:DATA_W];
        CMP_LO_OFS: rdata_o <= mtimecmp_q[DATA_W-1:0];
        CMP_HI_OFS: rdata_o <= mtimecmp_q[MT_W-1:DATA_W];
        default:    rdata_o <= '0;
      endcase
    end else begin
      rdata_o <= '0;
    end
  end

  // compare parked at all ones means no interrupt
  // counter itself at all ones is the only exception
  irq_parked_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    ($past(mtimecmp_q) == '1 && $past(mtime_q) != '1) |-> !mtimer_irq_o)
    else $error("mtimer: interrupt with compare disabled");

endmodule

/* design/rst_ctrl.sv */
// core boot address and fetch enable
module rst_ctrl (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [soc_pkg::WIN_BITS-1:0] offset_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic [soc_pkg::ADDR_W-1:0]   boot_addr_o,
  output logic                         fetch_en_o
);
  import soc_pkg::*;

  logic wr_en;
  logic rd_en;

  assign wr_en = sel_i & we_i;
  assign rd_en = sel_i & ~we_i;

  // start address and fetch enable registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_o <= DEFAULT_BOOT_ADDR;
      fetch_en_o  <= 1'b0;
    end else if (wr_en) begin
      case (offset_i)
        // word aligned start address
        RST_ADDR_OFS: boot_addr_o <= {wdata_i[ADDR_W-1:2], 2'b00};
        RST_CTRL_OFS: fetch_en_o  <= wdata_i[0];
        default: begin
          // unknown offset, write dropped
        end
      endcase
    end
  end

  // readback, loaded on the select cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      case (offset_i)
        RST_ADDR_OFS: rdata_o <= boot_addr_o;
        RST_CTRL_OFS: rdata_o <= {{(DATA_W-1){1'b0}}, fetch_en_o};
        default:      rdata_o <= '0;
      endcase
    end else begin
      rdata_o <= '0;
    end
  end

  // core may only start from a word boundary
  boot_aligned_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    boot_addr_o[1:0] == 2'b00)
    else $error("rst_ctrl: boot address not word aligned");

endmodule

/* design/data_ram.sv */
// word-addressed data memory slave
module data_ram #(
  parameter int RAM_WORDS = 2048
) (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [soc_pkg::WIN_BITS-1:0] offset_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o
);
  import soc_pkg::*;

  // word index width, depth is a power of two
  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic              wr_en;
  logic              rd_en;

  // byte offset to word index
  // upper offset bits dropped, so accesses wrap at the depth
  assign word_idx = offset_i[2 +: IDX_W];

  assign wr_en = sel_i & we_i;
  assign rd_en = sel_i & ~we_i;

  // storage array
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[word_idx] <= wdata_i;
    end
  end

  // read register, zero unless a read is selected
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      rdata_o <= mem[word_idx];
    end else begin
      rdata_o <= '0;
    end
  end

  // depth must fit inside the window
  initial begin
    assert (IDX_W + 2 <= WIN_BITS)
      else $error("data_ram: RAM_WORDS exceeds the address window");
  end

endmodule

/* design/bus_decoder.sv */
// single master address decoder
module bus_decoder (
  input  logic                                           clk,
  input  logic                                           arst_n_i,
  // master request, one-cycle strobe
  input  logic                                           req_i,
  input  logic                                           we_i,
  input  logic [soc_pkg::ADDR_W-1:0]                     addr_i,
  input  logic [soc_pkg::DATA_W-1:0]                     wdata_i,
  // master response, one cycle after the request
  output logic                                           rsp_o,
  output logic                                           err_o,
  output logic [soc_pkg::DATA_W-1:0]                     rdata_o,
  // slave side
  output logic [soc_pkg::N_SLAVES-1:0]                   sel_o,
  output logic                                           we_o,
  output logic [soc_pkg::WIN_BITS-1:0]                   offset_o,
  output logic [soc_pkg::DATA_W-1:0]                     wdata_o,
  input  logic [soc_pkg::N_SLAVES-1:0][soc_pkg::DATA_W-1:0] rdata_i
);
  import soc_pkg::*;

  // upper address bits that pick a window
  logic [ADDR_W-WIN_BITS-1:0] win_tag;
  logic [N_SLAVES-1:0]        hit;
  // request and hit vector of the previous cycle
  logic                       req_q;
  logic [N_SLAVES-1:0]        hit_q;
  logic [DATA_W-1:0]          rdata_mux;

  assign win_tag = addr_i[ADDR_W-1:WIN_BITS];

  // compare tag against each base
  always_comb begin
    hit            = '0;
    hit[SLV_RAM]   = (win_tag == RAM_BASE[ADDR_W-1:WIN_BITS]);
    hit[SLV_RST]   = (win_tag == RST_BASE[ADDR_W-1:WIN_BITS]);
    hit[SLV_GPIO]  = (win_tag == GPIO_BASE[ADDR_W-1:WIN_BITS]);
    hit[SLV_TIMER] = (win_tag == TIMER_BASE[ADDR_W-1:WIN_BITS]);
  end

  // selects only live while the strobe is up
  assign sel_o    = {N_SLAVES{req_i}} & hit;
  // every slave sees the same offset and data
  assign we_o     = we_i;
  assign offset_o = addr_i[WIN_BITS-1:0];
  assign wdata_o  = wdata_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
      hit_q <= '0;
    end else begin
      req_q <= req_i;
      hit_q <= sel_o;
    end
  end

  // slaves return zero when idle so a qualified OR is enough
  always_comb begin
    rdata_mux = '0;
    for (int i = 0; i < N_SLAVES; i++) begin
      if (hit_q[i]) begin
        rdata_mux = rdata_mux | rdata_i[i];
      end
    end
  end

  assign rsp_o   = req_q;
  // request that matched no window
  assign err_o   = req_q & ~(|hit_q);
  assign rdata_o = rdata_mux;

  // at most one window may claim an address
  sel_onehot_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0(sel_o))
    else $error("bus_decoder: overlapping slave selects");

  // every request answered exactly one cycle later
  rsp_latency_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    rsp_o == $past(req_i))
    else $error("bus_decoder: response not one cycle after request");

endmodule

/* design/soc_pkg.sv */
// peripheral fabric shared definitions
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // low address bits inside one slave window, 128 KiB each
  localparam int WIN_BITS = 17;

  // number of memory-mapped slaves
  localparam int N_SLAVES = 4;

  // window base addresses, only bits above WIN_BITS are decoded
  localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] RST_BASE   = 32'hC000_0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'hD000_0000;
  localparam logic [ADDR_W-1:0] TIMER_BASE = 32'hF000_0000;

  // slave index, also the bit position in the select vector
  typedef enum logic [1:0] {
    SLV_RAM   = 2'd0,
    SLV_RST   = 2'd1,
    SLV_GPIO  = 2'd2,
    SLV_TIMER = 2'd3
  } slave_idx_e;

  // reset controller registers
  localparam logic [WIN_BITS-1:0] RST_ADDR_OFS = 17'h0_0000;
  localparam logic [WIN_BITS-1:0] RST_CTRL_OFS = 17'h0_0004;

  // machine timer registers, 64-bit values split in halves
  localparam logic [WIN_BITS-1:0] TMR_LO_OFS = 17'h0_0000;
  localparam logic [WIN_BITS-1:0] TMR_HI_OFS = 17'h0_0004;
  localparam logic [WIN_BITS-1:0] CMP_LO_OFS = 17'h0_0008;
  localparam logic [WIN_BITS-1:0] CMP_HI_OFS = 17'h0_000C;

  // gpio output register
  localparam logic [WIN_BITS-1:0] GPIO_OUT_OFS = 17'h0_0000;

  // core start address out of reset, points at data ram
  localparam logic [ADDR_W-1:0] DEFAULT_BOOT_ADDR = 32'h1000_0000;

endpackage
